/* source/pkg_mem.sv */
// Memory geometry shared by the address generator, memory and testbench
// Addresses are word addresses, one word per location
// The address width fixes the depth, so address arithmetic wraps
// naturally modulo mem_depth and no range check exists anywhere

package pkg_mem;

	////////////////////
	// Geometry
	////////////////////

	localparam int addr_width	= 8;					// Word address bits
	localparam int mem_depth	= 1 << addr_width;		// 256 words
	localparam int data_width	= 32;					// Bits per memory word

	////////////////////
	// Types
	////////////////////

	// One word address
	typedef logic [addr_width-1:0]	addr_t;

	// One memory word
	typedef logic [data_width-1:0]	data_t;

endpackage

/* source/pkg_access.sv */
// Lane side definitions for the strided access engine
// Three lanes share one address generator through the arbiter
// A transfer length of 0 is executed as a single word

package pkg_access;

	////////////////////
	// Lanes
	////////////////////

	localparam int lane_count	= 3;					// Requesting lanes
	localparam int lane_width	= $clog2(lane_count);	// Lane index bits

	typedef logic [lane_width-1:0]	lane_t;				// Lane index

	////////////////////
	// Transfers
	////////////////////

	localparam int length_width	= 8;					// Length field bits

	typedef logic [length_width-1:0]	length_t;		// Words per transfer

endpackage

/* source/access_arbiter.sv */
// Round-robin arbiter for the lanes sharing the address generator
// A grant is held from issue until the done pulse of its transfer
// The lane must keep lane_req and its descriptor steady while granted
// Write data is routed live, so the lane steps it after each lane_beat
// After reset lane 0 has the highest priority

module access_arbiter (
	input									clock,
	input									reset,
	input	[pkg_access::lane_count-1:0]	lane_req,		// One request per lane
	input	[pkg_access::lane_count-1:0]	lane_write,		// Write flag per lane
	input	pkg_mem::addr_t [pkg_access::lane_count-1:0]		lane_base,
	input	pkg_mem::addr_t [pkg_access::lane_count-1:0]		lane_stride,
	input	pkg_access::length_t [pkg_access::lane_count-1:0]	lane_length,
	input	pkg_mem::data_t [pkg_access::lane_count-1:0]		lane_wdata,
	input									beat,			// Word completed
	input									done,			// Last word completed
	input									rdata_valid,	// Read word on rdata
	output	logic [pkg_access::lane_count-1:0]	lane_grant,
	output	logic [pkg_access::lane_count-1:0]	lane_beat,
	output	logic [pkg_access::lane_count-1:0]	lane_rdata_valid,
	output	logic							start,			// One cycle per grant
	output	logic							sel_write,
	output	pkg_mem::addr_t					sel_base,
	output	pkg_mem::addr_t					sel_stride,
	output	pkg_access::length_t			sel_length,
	output	pkg_mem::data_t					sel_wdata
);

	import pkg_mem::*;
	import pkg_access::*;

	lane_t						last_lane;		// Lane granted most recently
	lane_t						pick_lane;		// Round-robin winner index
	logic [lane_count-1:0]		pick;			// Round-robin winner one-hot

	////////////////////
	// Round-robin pick
	////////////////////

	// Search starts one above the last granted lane and wraps
	always_comb begin
		int		idx;
		logic	found;
		found		= 1'b0;
		pick		= '0;
		pick_lane	= last_lane;
		for (int i = 1; i <= lane_count; i++) begin
			idx = (int'(last_lane) + i) % lane_count;
			if (!found && lane_req[idx]) begin
				found		= 1'b1;
				pick[idx]	= 1'b1;
				pick_lane	= lane_t'(idx);
			end
		end
	end

	////////////////////
	// Grant register
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			lane_grant	<= '0;
			last_lane	<= lane_t'(lane_count - 1);		// Lane 0 wins first
			start		<= 1'b0;
		end
		else begin
			start		<= 1'b0;
			if (done) begin
				lane_grant	<= '0;						// Release on last beat
			end
			else if (lane_grant == '0 && |lane_req) begin
				lane_grant	<= pick;
				last_lane	<= pick_lane;
				start		<= 1'b1;					// Coincides with new grant
			end
		end
	end

	////////////////////
	// Descriptor mux
	////////////////////

	always_comb begin
		sel_write	= 1'b0;
		sel_base	= '0;
		sel_stride	= '0;
		sel_length	= '0;
		sel_wdata	= '0;
		for (int i = 0; i < lane_count; i++) begin
			if (lane_grant[i]) begin
				sel_write	= lane_write[i];
				sel_base	= lane_base[i];
				sel_stride	= lane_stride[i];
				sel_length	= lane_length[i];
				sel_wdata	= lane_wdata[i];			// Live, stepped per beat
			end
		end
	end

	assign lane_beat		= lane_grant & {lane_count{beat}};			// Steer to owner
	assign lane_rdata_valid	= lane_grant & {lane_count{rdata_valid}};	// Reads only

	// Exactly one lane owns the transfer that the generator finishes
	a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
		done |-> $onehot(lane_grant));

	// Owner holds its request until the transfer is released
	a_req_held: assert property (@(posedge clock) disable iff (reset)
		(lane_grant & ~lane_req) == '0);

endmodule

/* source/stride_agu.sv */
// Strided address generator with an APB master port
// One word per APB transfer, two cycles per word with zero wait states
// Word k goes to base + k * stride, wrapping at the memory depth
// Descriptor is latched on start, write data is taken live from the lane
// A length of 0 moves one word

module stride_agu (
	input							clock,
	input							reset,
	input							start,			// Begin a transfer
	input							sel_write,
	input	pkg_mem::addr_t			sel_base,
	input	pkg_mem::addr_t			sel_stride,
	input	pkg_access::length_t	sel_length,
	input	pkg_mem::data_t			sel_wdata,
	input	pkg_mem::data_t			prdata,
	input							pready,
	output	logic					beat,			// Access completed
	output	logic					done,			// Last access completed
	output	pkg_mem::data_t			rdata,
	output	logic					rdata_valid,
	output	logic					psel,
	output	logic					penable,
	output	logic					pwrite,
	output	pkg_mem::addr_t			paddr,
	output	pkg_mem::data_t			pwdata
);

	import pkg_mem::*;
	import pkg_access::*;

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t		state;
	logic		write_q;			// Latched direction
	addr_t		addr_q;				// Running word address
	addr_t		stride_q;			// Latched stride
	length_t	remaining;			// Words left, current one included
	logic		last;				// Current word is the final one

	assign last	= (remaining == length_t'(1));

	////////////////////
	// Transfer FSM
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= st_idle;
			write_q		<= 1'b0;
			remaining	<= '0;
		end
		else begin
			case (state)
				st_idle: begin
					if (start) begin
						state		<= st_setup;
						write_q		<= sel_write;
						remaining	<= (sel_length == '0) ? length_t'(1) : sel_length;
					end
				end
				st_setup: begin
					state	<= st_access;				// Always one setup cycle
				end
				st_access: begin
					if (pready) begin
						remaining	<= remaining - length_t'(1);
						state		<= last ? st_idle : st_setup;
					end
				end
				default: begin
					state	<= st_idle;
				end
			endcase
		end
	end

	// Base loaded on start, stride added after every completed word
	always_ff @(posedge clock) begin
		if (state == st_idle && start) begin
			addr_q		<= sel_base;
			stride_q	<= sel_stride;
		end
		else if (state == st_access && pready) begin
			addr_q		<= addr_q + stride_q;			// Wraps modulo mem_depth
		end
	end

	////////////////////
	// APB outputs
	////////////////////

	assign psel			= (state != st_idle);
	assign penable		= (state == st_access);
	assign pwrite		= psel & write_q;
	assign paddr		= psel ? addr_q : '0;
	assign pwdata		= pwrite ? sel_wdata : '0;		// Lane steps word after beat

	assign beat			= penable & pready;
	assign done			= beat & last;
	assign rdata_valid	= beat & ~write_q;
	assign rdata		= rdata_valid ? prdata : '0;	// Word passes on its beat

	// New transfer only arrives on an idle generator
	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		start |-> state == st_idle);

	// Address and write word held from setup into access
	a_paddr_stable: assert property (@(posedge clock) disable iff (reset)
		penable |-> $stable(paddr) && $stable(pwdata));

endmodule

/* source/shared_mem.sv */
// Single-port word memory behind an APB slave port
// Always ready, so every access completes in its first access cycle
// Contents start at zero and are not cleared by reset
// Reads are combinational from paddr, writes land at the end of access

module shared_mem (
	input						clock,
	input						reset,
	input						psel,
	input						penable,
	input						pwrite,
	input	pkg_mem::addr_t		paddr,
	input	pkg_mem::data_t		pwdata,
	output	pkg_mem::data_t		prdata,
	output	logic				pready
);

	import pkg_mem::*;

	data_t		mem [mem_depth];		// Word storage
	logic		write_en;				// Write in access phase

	////////////////////
	// Storage
	////////////////////

	initial begin
		for (int i = 0; i < mem_depth; i++) begin
			mem[i] = '0;				// Known contents at power up
		end
	end

	assign write_en	= psel & penable & pwrite & ~reset;

	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[paddr]	<= pwdata;
		end
	end

	////////////////////
	// Slave response
	////////////////////

	assign prdata	= psel ? mem[paddr] : '0;		// Valid from setup onward
	assign pready	= 1'b1;							// No wait states

endmodule

/* source/stride_engine_top.sv */
// Strided memory access engine, three lanes over one shared memory
// Lane descriptors and write data are packed arrays, one element per lane
// A lane holds lane_req and its descriptor until its final lane_beat
// rdata is shared and is only meaningful with the lane's lane_rdata_valid
// First beat comes three cycles after a request on an idle engine

module stride_engine_top (
	input									clock,
	input									reset,
	input	[pkg_access::lane_count-1:0]	lane_req,
	input	[pkg_access::lane_count-1:0]	lane_write,
	input	pkg_mem::addr_t [pkg_access::lane_count-1:0]		lane_base,
	input	pkg_mem::addr_t [pkg_access::lane_count-1:0]		lane_stride,
	input	pkg_access::length_t [pkg_access::lane_count-1:0]	lane_length,
	input	pkg_mem::data_t [pkg_access::lane_count-1:0]		lane_wdata,
	output	logic [pkg_access::lane_count-1:0]	lane_grant,
	output	logic [pkg_access::lane_count-1:0]	lane_beat,
	output	logic [pkg_access::lane_count-1:0]	lane_rdata_valid,
	output	pkg_mem::data_t					rdata
);

	import pkg_mem::*;
	import pkg_access::*;

	////////////////////
	// Arbiter to AGU
	////////////////////

	logic		start;
	logic		sel_write;
	addr_t		sel_base;
	addr_t		sel_stride;
	length_t	sel_length;
	data_t		sel_wdata;
	logic		beat;
	logic		done;
	logic		rdata_valid;

	////////////////////
	// APB
	////////////////////

	logic		psel;
	logic		penable;
	logic		pwrite;
	addr_t		paddr;
	data_t		pwdata;
	data_t		prdata;
	logic		pready;

	access_arbiter u_access_arbiter (
		.clock				(clock),
		.reset				(reset),
		.lane_req			(lane_req),
		.lane_write			(lane_write),
		.lane_base			(lane_base),
		.lane_stride		(lane_stride),
		.lane_length		(lane_length),
		.lane_wdata			(lane_wdata),
		.beat				(beat),
		.done				(done),
		.rdata_valid		(rdata_valid),
		.lane_grant			(lane_grant),
		.lane_beat			(lane_beat),
		.lane_rdata_valid	(lane_rdata_valid),
		.start				(start),
		.sel_write			(sel_write),
		.sel_base			(sel_base),
		.sel_stride			(sel_stride),
		.sel_length			(sel_length),
		.sel_wdata			(sel_wdata)
	);

	stride_agu u_stride_agu (
		.clock			(clock),
		.reset			(reset),
		.start			(start),
		.sel_write		(sel_write),
		.sel_base		(sel_base),
		.sel_stride		(sel_stride),
		.sel_length		(sel_length),
		.sel_wdata		(sel_wdata),
		.prdata			(prdata),
		.pready			(pready),
		.beat			(beat),
		.done			(done),
		.rdata			(rdata),
		.rdata_valid	(rdata_valid),
		.psel			(psel),
		.penable		(penable),
		.pwrite			(pwrite),
		.paddr			(paddr),
		.pwdata			(pwdata)
	);

	shared_mem u_shared_mem (
		.clock		(clock),
		.reset		(reset),
		.psel		(psel),
		.penable	(penable),
		.pwrite		(pwrite),
		.paddr		(paddr),
		.pwdata		(pwdata),
		.prdata		(prdata),
		.pready		(pready)
	);

endmodule

/* test/tb_clock.sv */
// Clock and reset source for the testbench
// 4 ns clock, reset high for the first 10 rising edges
// Reset falls 1 ns after an edge, like all other stimulus

module tb_clock (
	output logic	clock,
	output logic	reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;		// 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

/* test/tb_stride_engine.sv */
// Testbench for the strided access engine, driven from test/stride_golden.mem
// Records with equal tags are requested in the same cycle
// Outputs are sampled at the falling edge, inputs change 1 ns after the rising edge
// Write data comes from an xorshift sequence, read words are checked against a model

module tb_stride_engine;

	timeunit 1ns;
	timeprecision 1ps;

	import pkg_mem::*;
	import pkg_access::*;

	logic clock;
	logic reset;
	logic [lane_count-1:0] lane_req, lane_write, lane_grant, lane_beat, lane_rdata_valid;
	addr_t [lane_count-1:0] lane_base;
	addr_t [lane_count-1:0] lane_stride;
	length_t [lane_count-1:0] lane_length;
	data_t [lane_count-1:0] lane_wdata;
	data_t rdata;

	logic [31:0]	golden [256];			// Raw golden words
	data_t			ref_mem [mem_depth];	// Reference memory
	data_t			write_log [$];			// Written words in beat order
	int				rec_pos [$];			// Start of each record
	logic [31:0]	seed = 32'h82eea6f1;
	lane_t			last_lane;				// Round-robin pointer of the model
	int				limit_cycles;
	logic			limit_ready = 1'b0;

	tb_clock u_tb_clock (.clock(clock), .reset(reset));

	stride_engine_top u_stride_engine_top (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic data_t next_word();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic length_t eff_len(input length_t len);
		return (len == '0) ? length_t'(1) : len;		// Zero moves one word
	endfunction

	function automatic lane_t onehot_index(input logic [lane_count-1:0] v);
		lane_t idx;
		idx = '0;
		for (int i = 0; i < lane_count; i++) if (v[i]) idx = lane_t'(i);
		return idx;
	endfunction

	function automatic lane_t rr_pick(input lane_t last, input logic [lane_count-1:0] pend);
		for (int i = 1; i <= lane_count; i++) begin
			if (pend[(int'(last) + i) % lane_count]) return lane_t'((int'(last) + i) % lane_count);
		end
		return last;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_lane(input lane_t got, input lane_t exp, input string what);
		if (got !== exp) report_failure($sformatf("MISMATCH at %0t: %s got lane %0d expected %0d",
			$time, what, got, exp));
	endtask

	task automatic check_word(input data_t got, input data_t exp, input string what);
		if (got !== exp) report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
			$time, what, got, exp));
	endtask

	task automatic check_addr_count(input length_t got, input length_t exp, input string what);
		if (got !== exp) report_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
			$time, what, got, exp));
	endtask

	// Raise all requests of records first..last together, run until every transfer ends
	task automatic run_group(input int first, input int last);
		logic [lane_count-1:0] pending;
		int		pos [lane_count];
		lane_t	owner;
		logic	owned;
		logic	step;
		int		beats;
		int		p;
		int		k;
		addr_t	addr;
		data_t	gold;
		pending	= '0;
		owned	= 1'b0;
		owner	= '0;
		beats	= 0;
		for (int r = first; r <= last; r++) begin
			p = rec_pos[r];
			lane_write[golden[p]]	= golden[p+1][0];
			lane_base[golden[p]]	= addr_t'(golden[p+2]);
			lane_stride[golden[p]]	= addr_t'(golden[p+3]);
			lane_length[golden[p]]	= length_t'(golden[p+4]);
			lane_wdata[golden[p]]	= golden[p+1][0] ? next_word() : '0;	// First word up front
			lane_req[golden[p]]		= 1'b1;
			pending[golden[p]]		= 1'b1;
			pos[golden[p]]			= p + 6;
		end
		while (pending != '0 || owned) begin
			@(negedge clock);
			step = 1'b0;
			if (!$onehot0(lane_grant)) report_failure("Grant is held by more than one lane");
			if ((lane_beat & ~lane_grant) != '0) report_failure("A beat reached a lane without grant");
			if (!owned && lane_grant != '0) begin
				check_lane(onehot_index(lane_grant), rr_pick(last_lane, pending), "grant order");
				owner		= onehot_index(lane_grant);
				last_lane	= owner;
				owned		= 1'b1;
				beats		= 0;
			end
			else if (owned && lane_grant == '0) begin
				check_addr_count(length_t'(beats), eff_len(lane_length[owner]), "beats per transfer");
				pending[owner]	= 1'b0;
				owned			= 1'b0;
			end
			else if (owned && !lane_req[owner]) report_failure("Grant was kept after the last beat");
			if (owned && lane_beat[owner]) begin
				if (beats >= int'(eff_len(lane_length[owner])))
					report_failure("More beats than the transfer length");
				addr = addr_t'(lane_base[owner] + addr_t'(beats) * lane_stride[owner]);	// Wraps
				if (lane_write[owner]) begin
					if (lane_rdata_valid != '0) report_failure("Read data valid during a write");
					ref_mem[addr] = lane_wdata[owner];
					write_log.push_back(lane_wdata[owner]);
					step = 1'b1;
				end
				else begin
					if (lane_rdata_valid != lane_beat) report_failure("Read data valid missed a beat");
					k = golden[pos[owner] + beats];
					if (k > write_log.size()) report_failure("Golden word names a missing write");
					gold = (k == 0) ? '0 : write_log[k-1];
					check_word(ref_mem[addr], gold, "model against golden");
					check_word(rdata, ref_mem[addr], "read data");
				end
				beats++;
			end
			else if (lane_rdata_valid != '0) report_failure("Read data valid without a beat");
			@(posedge clock);
			#1;
			if (owned && beats == int'(eff_len(lane_length[owner]))) lane_req[owner] = 1'b0;
			else if (step) lane_wdata[owner] = next_word();		// Next word after beat
		end
		repeat (2) begin
			@(negedge clock);
			if (lane_grant != '0 || lane_beat != '0) report_failure("Grant or beat while idle");
		end
		@(posedge clock);
		#1;
	endtask

	initial begin
		int p;
		int n;
		int e;
		int r;
		lane_req = '0;
		lane_write = '0;
		lane_base = '0;
		lane_stride = '0;
		lane_length = '0;
		lane_wdata = '0;
		last_lane = lane_t'(lane_count - 1);		// Lane 0 wins first
		for (int i = 0; i < mem_depth; i++) ref_mem[i] = '0;
		$readmemh("test/stride_golden.mem", golden);
		n = golden[0];
		p = 1;
		limit_cycles = 110;
		for (int i = 0; i < n; i++) begin
			rec_pos.push_back(p);
			limit_cycles += 2 * int'(eff_len(length_t'(golden[p+4]))) + 8;
			p += 6 + (golden[p+1][0] ? 0 : int'(eff_len(length_t'(golden[p+4]))));
		end
		limit_ready = 1'b1;
		@(negedge reset);
		repeat (2) begin
			@(negedge clock);
			if (lane_grant != '0 || lane_beat != '0) report_failure("Grant or beat after reset");
		end
		@(posedge clock);
		#1;
		r = 0;
		while (r < n) begin
			e = r;
			while (e + 1 < n && golden[rec_pos[e+1] + 5] == golden[rec_pos[r] + 5]) e++;
			run_group(r, e);
			r = e + 1;
		end
		$display("All checks passed");
		$finish;
	end

	// Watchdog sized from the transfer list
	initial begin
		wait (limit_ready);
		repeat (limit_cycles) @(posedge clock);
		report_failure("Simulation timed out before all transfers finished");
	end

endmodule

/* compile.f */
source/pkg_mem.sv
source/pkg_access.sv
source/access_arbiter.sv
source/stride_agu.sv
source/shared_mem.sv
source/stride_engine_top.sv
test/tb_clock.sv
test/tb_stride_engine.sv

/* Makefile */
VERILATOR	= verilator
VFLAGS		= --binary --assert -Wall -Wno-fatal
TOP			= tb_stride_engine
FILELIST	= compile.f
OBJ_DIR		= obj_dir
LOG			= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/stride_golden.mem */
// Record: lane write base stride length tag, then for reads one word per moved word
// Read words are ordinals into the beat-ordered write log, 0 means never written
7
2 1 10 03 04 1
0 0 10 03 04 2
1 2 3 4
1 1 f0 08 04 2
2 1 40 02 00 2
1 0 f0 08 04 3
5 6 7 8
2 0 3c 02 04 3
0 0 9 0
0 0 00 08 03 4
7 8 1
